//--- dv/bytecode_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bytecode_core_tb;

    localparam int max_tests = 64;
    localparam int clk_period = 10;
    localparam int reset_cycles = 4;
    localparam int cycles_per_test = 100;
    localparam int nop_window = 20;  // cycles a nop must stay without op_done

    typedef struct packed {
        logic [jvm_pkg::byte_w-1:0]   op;
        logic [jvm_pkg::byte_w-1:0]   arg1;
        logic [jvm_pkg::byte_w-1:0]   arg2;
        logic [1:0]                   count;   // values preloaded
        logic [jvm_pkg::word_w-1:0]   pre_a;   // pushed first
        logic [jvm_pkg::word_w-1:0]   pre_b;
        logic                         push;
        logic [jvm_pkg::word_w-1:0]   value;
        logic [jvm_pkg::offset_w-1:0] offset;
        logic [3:0]                   depth;
    } vector_t;

    logic                         clk;
    logic                         rst;
    logic [jvm_pkg::byte_w-1:0]   op_code;
    logic [jvm_pkg::byte_w-1:0]   arg1;
    logic [jvm_pkg::byte_w-1:0]   arg2;
    logic [jvm_pkg::offset_w-1:0] offset;
    logic                         op_done;
    logic                         evalpush;
    logic                         evaltrigger;
    logic [jvm_pkg::word_w-1:0]   evalwrite;
    logic [jvm_pkg::word_w-1:0]   evalread;
    logic                         evaldone;
    logic                         preload;
    logic [1:0]                   preload_count;
    logic [jvm_pkg::word_w-1:0]   preload_a;
    logic [jvm_pkg::word_w-1:0]   preload_b;
    logic [3:0]                   depth;

    vector_t                      vectors [max_tests];
    string                        names [max_tests];
    int                           test_count = 0;
    int                           pass_count = 0;
    int                           fail_count = 0;
    int unsigned                  push_count;
    logic [jvm_pkg::word_w-1:0]   last_push;

    bytecode_core bytecode_core_i (
        .clk         (clk),
        .rst         (rst),
        .op_code     (op_code),
        .arg1        (arg1),
        .arg2        (arg2),
        .offset      (offset),
        .op_done     (op_done),
        .evalpush    (evalpush),
        .evaltrigger (evaltrigger),
        .evalwrite   (evalwrite),
        .evalread    (evalread),
        .evaldone    (evaldone)
    );

    eval_stack_model stack_model_i (
        .clk           (clk),
        .rst           (rst),
        .trigger       (evaltrigger),
        .push          (evalpush),
        .write_data    (evalwrite),
        .read_data     (evalread),
        .done          (evaldone),
        .preload       (preload),
        .preload_count (preload_count),
        .preload_a     (preload_a),
        .preload_b     (preload_b),
        .depth         (depth)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // record every push the core sends to the stack
    always @(posedge clk) begin
        if (rst) begin
            push_count <= 0;
        end else if (evaltrigger && evalpush) begin
            push_count <= push_count + 1;
            last_push <= evalwrite;
        end
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f [10];
        fd = $fopen("dv/bytecode_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/bytecode_vectors.txt");
            return;
        end
        while ($fgets(line, fd) != 0 && test_count < max_tests) begin
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n != 11) continue;  // blank line
            names[test_count] = name;
            vectors[test_count] = '{op: f[0][7:0], arg1: f[1][7:0], arg2: f[2][7:0],
                                    count: f[3][1:0], pre_a: f[4], pre_b: f[5],
                                    push: f[6][0], value: f[7], offset: f[8][15:0],
                                    depth: f[9][3:0]};
            test_count++;
        end
        $fclose(fd);
    endtask

    task automatic run_test(input string name, input vector_t v);
        int unsigned pushes_before;
        int          fails;
        int          seen;
        fails = 0;
        seen = 0;
        pushes_before = push_count;
        @(posedge clk);
        preload <= 1'b1;
        preload_count <= v.count;
        preload_a <= v.pre_a;
        preload_b <= v.pre_b;
        op_code <= v.op;
        arg1 <= v.arg1;
        arg2 <= v.arg2;
        @(posedge clk);
        preload <= 1'b0;
        if (v.op == jvm_pkg::nop) begin
            repeat (nop_window) begin
                @(posedge clk);
                if (op_done) seen++;
            end
            if (seen != 0) begin
                $display("%0s: op_done arrived while only a nop was on op_code", name);
                fails++;
            end
        end else begin
            do begin
                @(posedge clk);
            end while (!op_done);
            op_code <= jvm_pkg::nop;  // keep the decoder from running it again
            if (offset !== v.offset) begin
                $display("[ERROR] %0t %0s: offset expected %h, got %h",
                         $time, name, v.offset, offset);
                fails++;
            end
        end
        if (v.push && push_count != pushes_before + 1) begin
            $display("%0s: expected one push, saw %0d", name, push_count - pushes_before);
            fails++;
        end
        if (!v.push && push_count != pushes_before) begin
            $display("%0s: a value was pushed although none was expected", name);
            fails++;
        end
        if (v.push && last_push !== v.value) begin
            $display("[ERROR] %0t %0s: evalwrite expected %h, got %h",
                     $time, name, v.value, last_push);
            fails++;
        end
        if (depth !== v.depth) begin
            $display("[ERROR] %0t %0s: depth expected %0d, got %0d", $time, name, v.depth, depth);
            fails++;
        end
        if (fails == 0) begin
            pass_count++;
            $display("PASS %0s", name);
        end else begin
            fail_count++;
            $display("FAIL %0s", name);
        end
    endtask

    initial begin
        rst = 1'b1;
        op_code = jvm_pkg::nop;
        arg1 = '0;
        arg2 = '0;
        preload = 1'b0;
        preload_count = '0;
        preload_a = '0;
        preload_b = '0;
        load_vectors();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < test_count; i++) begin
            run_test(names[i], vectors[i]);
        end
        if (test_count == 0) $display("no test vectors were read");
        $display("tests: %0d  passed: %0d  failed: %0d", test_count, pass_count, fail_count);
        if (fail_count == 0 && test_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // run limit scales with the number of tests read, counted once reset is released
    initial begin
        wait (rst === 1'b0 && test_count > 0);
        repeat (test_count * cycles_per_test) @(posedge clk);
        $display("timeout: the tests did not finish in %0d cycles",
                 test_count * cycles_per_test + reset_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/bytecode_vectors.txt
# name op arg1 arg2 count pre_a pre_b push value offset depth, all but name in hex
# pre_a is pushed first, so pre_b is the top of stack when count is 2
iconst_m1    02 00 00 0 00000000 00000000 1 ffffffff 0001 1
iconst_5     08 00 00 1 0000abcd 00000000 1 00000005 0001 2
bipush_neg   10 f6 00 0 00000000 00000000 1 fffffff6 0002 1
sipush_neg   11 80 05 0 00000000 00000000 1 ffff8005 0003 1
sipush_pos   11 12 34 0 00000000 00000000 1 00001234 0003 1
iadd         60 00 00 2 00000007 fffffffb 1 00000002 0001 1
isub         64 00 00 2 00000003 0000000a 1 fffffff9 0001 1
iand         7e 00 00 2 f0f0ff00 0ff0f0f0 1 00f0f000 0001 1
ior          80 00 00 2 f0f0ff00 0ff0f0f0 1 fff0fff0 0001 1
ixor         82 00 00 2 f0f0ff00 0ff0f0f0 1 ff000ff0 0001 1
ifeq_zero    99 00 20 1 00000000 00000000 0 00000000 0020 0
ifeq_pos     99 00 20 1 00000005 00000000 0 00000000 0003 0
ifne_neg     9a 00 20 1 ffffffff 00000000 0 00000000 0020 0
ifne_zero    9a 00 20 1 00000000 00000000 0 00000000 0003 0
iflt_neg     9b 00 20 1 80000000 00000000 0 00000000 0020 0
iflt_zero    9b 00 20 1 00000000 00000000 0 00000000 0003 0
ifge_zero    9c 00 20 1 00000000 00000000 0 00000000 0020 0
ifge_neg     9c 00 20 1 fffffff0 00000000 0 00000000 0003 0
ifgt_pos     9d 00 20 1 7fffffff 00000000 0 00000000 0020 0
ifgt_zero    9d 00 20 1 00000000 00000000 0 00000000 0003 0
ifle_neg     9e 00 20 1 fffffffe 00000000 0 00000000 0020 0
ifle_pos     9e 00 20 1 00000003 00000000 0 00000000 0003 0
icmplt_taken a1 01 00 2 ffffffff 00000001 0 00000000 0100 0
icmplt_not   a1 01 00 2 00000002 fffffffe 0 00000000 0003 0
icmpgt_taken a3 01 00 2 00000002 fffffffe 0 00000000 0100 0
icmpgt_not   a3 01 00 2 80000000 7fffffff 0 00000000 0003 0
goto         a7 12 34 1 00000009 00000000 0 00000000 1234 1
nop_skip     00 00 00 1 00000011 00000000 0 00000000 0000 1
pop          57 00 00 2 00000021 00000022 0 00000000 0001 1

//--- dv/eval_stack_model.sv
`timescale 1ns/1ps
`default_nettype none

module eval_stack_model (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       trigger,
    input  logic                       push,
    input  logic [jvm_pkg::word_w-1:0] write_data,
    output logic [jvm_pkg::word_w-1:0] read_data,
    output logic                       done,
    input  logic                       preload,
    input  logic [1:0]                 preload_count,
    input  logic [jvm_pkg::word_w-1:0] preload_a,  // bottom entry
    input  logic [jvm_pkg::word_w-1:0] preload_b,
    output logic [3:0]                 depth
);

    logic [jvm_pkg::word_w-1:0] mem [0:15];
    logic [2:0]                 delay;      // cycles left until done
    logic                       busy;
    logic                       req_push;
    logic [jvm_pkg::word_w-1:0] req_data;
    integer                     seed = 52;
    integer                     r;

    always @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            depth <= '0;
            delay <= '0;
            read_data <= '0;
        end else begin
            done <= 1'b0;
            if (preload) begin
                depth <= {2'b00, preload_count};
                mem[0] <= preload_a;
                mem[1] <= preload_b;
            end else if (trigger && !busy) begin
                r = $random(seed);
                delay <= 3'(r[1:0]) + 3'd1;  // done comes 1 to 4 cycles later
                busy <= 1'b1;
                req_push <= push;
                req_data <= write_data;
            end else if (busy) begin
                if (delay == 3'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    if (req_push) begin
                        mem[depth] <= req_data;
                        depth <= depth + 4'd1;
                    end else begin
                        read_data <= mem[depth - 4'd1];  // top of stack
                        depth <= depth - 4'd1;
                    end
                end else begin
                    delay <= delay - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- flist.f
source/jvm_pkg.sv
source/opcode_decoder.sv
source/operand_fetch.sv
source/execute_stage.sv
source/writeback_stage.sv
source/eval_stack_port.sv
source/bytecode_core.sv
dv/eval_stack_model.sv
dv/bytecode_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bytecode core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bytecode_core_tb \
    -f flist.f -o sim_bytecode_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_bytecode_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$log"; then
    exit 0
fi
exit 1

//--- source/bytecode_core.sv
`timescale 1ns/1ps
`default_nettype none

module bytecode_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [jvm_pkg::byte_w-1:0]    op_code,
    input  logic [jvm_pkg::byte_w-1:0]    arg1,
    input  logic [jvm_pkg::byte_w-1:0]    arg2,
    output logic [jvm_pkg::offset_w-1:0]  offset,
    output logic                          op_done,
    output logic                          evalpush,
    output logic                          evaltrigger,
    output logic [jvm_pkg::word_w-1:0]    evalwrite,
    input  logic [jvm_pkg::word_w-1:0]    evalread,
    input  logic                          evaldone
);

    logic                  dec_valid;
    logic                  opnd_valid;
    logic                  res_valid;
    jvm_pkg::decoded_op_t  dec;
    jvm_pkg::operand_pkt_t opnd;
    jvm_pkg::result_pkt_t  res;
    jvm_pkg::stack_req_t   fetch_req;
    jvm_pkg::stack_req_t   wb_req;
    logic                  fetch_trigger;
    logic                  fetch_done;
    logic                  wb_trigger;
    logic                  wb_done;

    opcode_decoder opcode_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .op_code   (op_code),
        .arg1      (arg1),
        .arg2      (arg2),
        .op_done   (op_done),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    operand_fetch operand_fetch_i (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .req         (fetch_req),
        .req_trigger (fetch_trigger),
        .done        (fetch_done),
        .read_data   (evalread),
        .opnd_valid  (opnd_valid),
        .opnd        (opnd)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .rst        (rst),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .res_valid  (res_valid),
        .res        (res)
    );

    writeback_stage writeback_stage_i (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res         (res),
        .req         (wb_req),
        .req_trigger (wb_trigger),
        .done        (wb_done),
        .op_done     (op_done),
        .offset      (offset)
    );

    eval_stack_port eval_stack_port_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_trigger (fetch_trigger),
        .wb_req        (wb_req),
        .wb_trigger    (wb_trigger),
        .fetch_done    (fetch_done),
        .wb_done       (wb_done),
        .evalpush      (evalpush),
        .evaltrigger   (evaltrigger),
        .evalwrite     (evalwrite),
        .evaldone      (evaldone)
    );

endmodule

`default_nettype wire

//--- source/eval_stack_port.sv
`timescale 1ns/1ps
`default_nettype none

module eval_stack_port (
    input  logic                          clk,
    input  logic                          rst,
    input  jvm_pkg::stack_req_t           fetch_req,
    input  logic                          fetch_trigger,
    input  jvm_pkg::stack_req_t           wb_req,
    input  logic                          wb_trigger,
    output logic                          fetch_done,
    output logic                          wb_done,
    output logic                          evalpush,
    output logic                          evaltrigger,
    output logic [jvm_pkg::word_w-1:0]    evalwrite,
    input  logic                          evaldone
);

    jvm_pkg::stack_req_t active;
    logic                owner_wb;  // outstanding request came from writeback

    assign active = wb_trigger ? wb_req : fetch_req;
    assign evalpush = active.push;
    assign evalwrite = active.data;
    assign evaltrigger = fetch_trigger | wb_trigger;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_wb <= 1'b0;
        end else if (wb_trigger) begin
            owner_wb <= 1'b1;
        end else if (fetch_trigger) begin
            owner_wb <= 1'b0;
        end
    end

    // done goes only to the stage that asked
    assign fetch_done = evaldone & ~owner_wb;
    assign wb_done = evaldone & owner_wb;

    a_single_requester: assert property (@(posedge clk) disable iff (rst)
        !(fetch_trigger && wb_trigger));

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          opnd_valid,
    input  jvm_pkg::operand_pkt_t         opnd,
    output logic                          res_valid,
    output jvm_pkg::result_pkt_t          res
);

    logic [jvm_pkg::word_w-1:0]   a;
    logic [jvm_pkg::word_w-1:0]   b;
    logic [jvm_pkg::word_w-1:0]   alu_out;
    logic [jvm_pkg::word_w-1:0]   literal;
    logic [jvm_pkg::word_w-1:0]   value;
    logic [jvm_pkg::offset_w-1:0] next_offset;
    logic                         lt;
    logic                         eq;
    logic                         taken;

    assign a = opnd.operand_a;
    assign b = opnd.dec.cmp_zero ? '0 : opnd.operand_b;

    always_comb begin
        case (opnd.dec.alu_op)
            jvm_pkg::alu_add: alu_out = a + opnd.operand_b;
            jvm_pkg::alu_sub: alu_out = a - opnd.operand_b;
            jvm_pkg::alu_and: alu_out = a & opnd.operand_b;
            jvm_pkg::alu_or:  alu_out = a | opnd.operand_b;
            default:          alu_out = a ^ opnd.operand_b;
        endcase
    end

    // a negative a is below a non-negative b and equal signs compare by magnitude
    assign eq = (a == b);
    assign lt = (a[31] != b[31]) ? a[31] : (a < b);

    always_comb begin
        case (opnd.dec.cmp_kind)
            jvm_pkg::cmp_eq: taken = eq;
            jvm_pkg::cmp_ne: taken = !eq;
            jvm_pkg::cmp_lt: taken = lt;
            jvm_pkg::cmp_ge: taken = !lt;
            jvm_pkg::cmp_gt: taken = !lt && !eq;
            default:         taken = lt || eq;
        endcase
    end

    // bipush takes one byte and sipush two with arg1 high
    assign literal = (opnd.dec.argc == 2'd1) ?
        {{24{opnd.dec.arg1[7]}}, opnd.dec.arg1} :
        {{16{opnd.dec.arg1[7]}}, opnd.dec.arg1, opnd.dec.arg2};

    assign value = opnd.dec.is_alu     ? alu_out :
                   opnd.dec.is_literal ? literal :
                   opnd.dec.is_const   ? opnd.dec.const_val : '0;

    assign next_offset = (opnd.dec.is_goto || (opnd.dec.is_cmp && taken)) ?
        {opnd.dec.arg1, opnd.dec.arg2} :
        {{(jvm_pkg::offset_w - 2){1'b0}}, opnd.dec.argc} + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= opnd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd_valid) begin
            res.stack_wb <= opnd.dec.stack_wb;
            res.value <= value;
            res.offset <= next_offset;
        end
    end

endmodule

`default_nettype wire

//--- source/jvm_pkg.sv
`default_nettype none

package jvm_pkg;

    localparam int word_w = 32;
    localparam int offset_w = 16;
    localparam int byte_w = 8;

    // idle cycles after op_done before the next opcode is sampled
    localparam int fetch_wait_w = 2;
    localparam logic [fetch_wait_w-1:0] fetch_wait_cycles = 2'd3;

    localparam logic [byte_w-1:0] nop       = 8'h00;
    localparam logic [byte_w-1:0] iconst_m1 = 8'h02;
    localparam logic [byte_w-1:0] iconst_0  = 8'h03; // base of the constant value
    localparam logic [byte_w-1:0] iconst_5  = 8'h08;
    localparam logic [byte_w-1:0] bipush    = 8'h10;
    localparam logic [byte_w-1:0] sipush    = 8'h11;
    localparam logic [byte_w-1:0] pop       = 8'h57;
    localparam logic [byte_w-1:0] iadd      = 8'h60;
    localparam logic [byte_w-1:0] isub      = 8'h64;
    localparam logic [byte_w-1:0] iand      = 8'h7e;
    localparam logic [byte_w-1:0] ior       = 8'h80;
    localparam logic [byte_w-1:0] ixor      = 8'h82;
    localparam logic [byte_w-1:0] ifeq      = 8'h99;
    localparam logic [byte_w-1:0] ifle      = 8'h9e;
    localparam logic [byte_w-1:0] if_icmpeq = 8'h9f;
    localparam logic [byte_w-1:0] if_icmple = 8'ha4;
    localparam logic [byte_w-1:0] goto_op   = 8'ha7;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor
    } alu_op_e;

    // same order as the opcodes so the kind is the opcode minus the first of its group
    typedef enum logic [2:0] {
        cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_gt, cmp_le
    } cmp_kind_e;

    typedef struct packed {
        logic              is_alu;
        alu_op_e           alu_op;
        logic              is_cmp;
        cmp_kind_e         cmp_kind;
        logic              cmp_zero;    // compare operand a against zero
        logic              is_goto;
        logic              is_const;
        logic [word_w-1:0] const_val;
        logic              is_literal;  // bipush or sipush
        logic [1:0]        argc;        // code bytes after the opcode
        logic [1:0]        pops;        // stack values consumed
        logic              stack_wb;
        logic [byte_w-1:0] arg1;
        logic [byte_w-1:0] arg2;
    } decoded_op_t;

    typedef struct packed {
        decoded_op_t       dec;
        logic [word_w-1:0] operand_a;
        logic [word_w-1:0] operand_b;
    } operand_pkt_t;

    typedef struct packed {
        logic                stack_wb;
        logic [word_w-1:0]   value;
        logic [offset_w-1:0] offset;
    } result_pkt_t;

    typedef struct packed {
        logic              push;   // low for a pop
        logic [word_w-1:0] data;
    } stack_req_t;

endpackage

`default_nettype wire

//--- source/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [jvm_pkg::byte_w-1:0]    op_code,
    input  logic [jvm_pkg::byte_w-1:0]    arg1,
    input  logic [jvm_pkg::byte_w-1:0]    arg2,
    input  logic                          op_done,
    output logic                          dec_valid,
    output jvm_pkg::decoded_op_t          dec
);

    logic                              busy;      // instruction in flight
    logic [jvm_pkg::fetch_wait_w-1:0]  wait_cnt;
    logic                              known;
    logic                              sample;
    logic [jvm_pkg::byte_w-1:0]        const_byte;
    jvm_pkg::decoded_op_t              dec_next;

    assign const_byte = op_code - jvm_pkg::iconst_0; // -1 .. 5 as a byte
    assign sample = !busy && (wait_cnt == '0) && known;

    always_comb begin
        dec_next = '0;
        dec_next.arg1 = arg1;
        dec_next.arg2 = arg2;
        known = 1'b1;
        case (op_code) inside
            [jvm_pkg::iconst_m1 : jvm_pkg::iconst_5]: begin
                dec_next.is_const = 1'b1;
                dec_next.const_val = {{(jvm_pkg::word_w - jvm_pkg::byte_w){const_byte[7]}},
                                      const_byte};
                dec_next.stack_wb = 1'b1;
            end
            jvm_pkg::bipush, jvm_pkg::sipush: begin
                dec_next.is_literal = 1'b1;
                dec_next.argc = (op_code == jvm_pkg::bipush) ? 2'd1 : 2'd2;
                dec_next.stack_wb = 1'b1;
            end
            jvm_pkg::pop: dec_next.pops = 2'd1;
            jvm_pkg::iadd, jvm_pkg::isub, jvm_pkg::iand, jvm_pkg::ior, jvm_pkg::ixor: begin
                dec_next.is_alu = 1'b1;
                dec_next.pops = 2'd2;
                dec_next.stack_wb = 1'b1;
                case (op_code)
                    jvm_pkg::iadd: dec_next.alu_op = jvm_pkg::alu_add;
                    jvm_pkg::isub: dec_next.alu_op = jvm_pkg::alu_sub;
                    jvm_pkg::iand: dec_next.alu_op = jvm_pkg::alu_and;
                    jvm_pkg::ior:  dec_next.alu_op = jvm_pkg::alu_or;
                    default:       dec_next.alu_op = jvm_pkg::alu_xor;
                endcase
            end
            [jvm_pkg::ifeq : jvm_pkg::ifle]: begin
                dec_next.is_cmp = 1'b1;
                dec_next.cmp_zero = 1'b1;
                dec_next.cmp_kind = jvm_pkg::cmp_kind_e'(3'(op_code - jvm_pkg::ifeq));
                dec_next.argc = 2'd2;
                dec_next.pops = 2'd1;
            end
            [jvm_pkg::if_icmpeq : jvm_pkg::if_icmple]: begin
                dec_next.is_cmp = 1'b1;
                dec_next.cmp_kind = jvm_pkg::cmp_kind_e'(3'(op_code - jvm_pkg::if_icmpeq));
                dec_next.argc = 2'd2;
                dec_next.pops = 2'd2;
            end
            jvm_pkg::goto_op: begin
                dec_next.is_goto = 1'b1;
                dec_next.argc = 2'd2;
            end
            default: known = 1'b0; // nop and unsupported codes keep the decoder waiting
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            wait_cnt <= jvm_pkg::fetch_wait_cycles;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b0;
            if (op_done) begin
                busy <= 1'b0;
                wait_cnt <= jvm_pkg::fetch_wait_cycles; // give the fetch unit time to move
            end else if (!busy) begin
                if (wait_cnt != '0) begin
                    wait_cnt <= wait_cnt - 1'b1;
                end else if (known) begin
                    busy <= 1'b1;
                    dec_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            dec <= dec_next;
        end
    end

    // completion only ever belongs to an instruction this decoder started
    a_done_while_busy: assert property (@(posedge clk) disable iff (rst) op_done |-> busy);

endmodule

`default_nettype wire

//--- source/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dec_valid,
    input  jvm_pkg::decoded_op_t          dec,
    output jvm_pkg::stack_req_t           req,
    output logic                          req_trigger,
    input  logic                          done,
    input  logic [jvm_pkg::word_w-1:0]    read_data,
    output logic                          opnd_valid,
    output jvm_pkg::operand_pkt_t         opnd
);

    logic [1:0] pops_left;  // includes the pop in flight
    logic       pending;    // pop issued, done not yet seen
    logic       pop_back;

    assign req = '{push: 1'b0, data: '0}; // this stage only ever pops
    assign pop_back = pending && done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pops_left <= '0;
            pending <= 1'b0;
            req_trigger <= 1'b0;
            opnd_valid <= 1'b0;
        end else begin
            req_trigger <= 1'b0;
            opnd_valid <= 1'b0;
            pending <= (pending & ~done) | req_trigger;
            if (dec_valid) begin
                pops_left <= dec.pops;
                if (dec.pops == 2'd0) begin
                    opnd_valid <= 1'b1;
                end else begin
                    req_trigger <= 1'b1;
                end
            end else if (pop_back) begin
                pops_left <= pops_left - 1'b1;
                if (pops_left == 2'd1) begin
                    opnd_valid <= 1'b1;  // last operand in
                end else begin
                    req_trigger <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            opnd.dec <= dec;
            opnd.operand_a <= '0;
            opnd.operand_b <= '0;
        end else if (pop_back) begin
            // top of stack is the second operand when two are popped
            if (pops_left == 2'd2) begin
                opnd.operand_b <= read_data;
            end else begin
                opnd.operand_a <= read_data;
            end
        end
    end

    a_one_pop_at_a_time: assert property (@(posedge clk) disable iff (rst)
        req_trigger |-> !pending);

endmodule

`default_nettype wire

//--- source/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          res_valid,
    input  jvm_pkg::result_pkt_t          res,
    output jvm_pkg::stack_req_t           req,
    output logic                          req_trigger,
    input  logic                          done,
    output logic                          op_done,
    output logic [jvm_pkg::offset_w-1:0]  offset
);

    logic                         waiting;     // push issued, waiting for done
    logic [jvm_pkg::offset_w-1:0] held_offset; // released with op_done

    always_ff @(posedge clk) begin
        if (rst) begin
            req_trigger <= 1'b0;
            waiting <= 1'b0;
            op_done <= 1'b0;
            offset <= '0;
        end else begin
            req_trigger <= 1'b0;
            op_done <= 1'b0;
            if (res_valid && res.stack_wb) begin
                req_trigger <= 1'b1;
                waiting <= 1'b1;
            end else if (res_valid) begin
                op_done <= 1'b1;          // nothing to push
                offset <= res.offset;
            end else if (waiting && done) begin
                waiting <= 1'b0;
                op_done <= 1'b1;
                offset <= held_offset;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            held_offset <= res.offset;
            req <= '{push: 1'b1, data: res.value};
        end
    end

    a_done_is_pulse: assert property (@(posedge clk) disable iff (rst) op_done |=> !op_done);

endmodule

`default_nettype wire
